// File: risc8.f
+incdir+tb
src/risc8_pkg.sv
src/risc8_decode.sv
src/risc8_regs.sv
src/risc8_alu.sv
src/risc8_core.sv
tb/risc8_tb.sv

// File: Makefile
# Verilator simulation of the risc8 core

VERILATOR ?= verilator
TOP ?= risc8_tb
FILELIST ?= risc8.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/risc8_ref.svh
/*
 * instruction-set model of the risc8 subset
 * runs the ROM one instruction at a time and lists the expected I/O writes
 */
`ifndef RISC8_REF_SVH
`define RISC8_REF_SVH

logic [7:0] m_regs [32];
logic [7:0] m_sreg;

// add or subtract with AVR flags, borrow taken from bit 8 of a 9-bit difference
function automatic logic [7:0] model_arith(input logic [7:0] a, input logic [7:0] b,
		input logic sub, input logic with_c);
	logic cin;
	logic [8:0] full;
	logic [4:0] low;
	logic v;
	cin = with_c & m_sreg[0];
	if (sub) begin
		full = {1'b0, a} - {1'b0, b} - {8'b0, cin};
		low = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, cin};
		v = (a[7] != b[7]) && (full[7] != a[7]);
	end else begin
		full = {1'b0, a} + {1'b0, b} + {8'b0, cin};
		low = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, cin};
		v = (a[7] == b[7]) && (full[7] != a[7]);
	end
	m_sreg[0] = full[8];
	m_sreg[5] = low[4];
	m_sreg[3] = v;
	m_sreg[2] = full[7];
	m_sreg[4] = full[7] ^ v;
	// with-carry subtracts chain Z over the bytes
	m_sreg[1] = (full[7:0] == 8'h00) && (!(sub && with_c) || m_sreg[1]);
	return full[7:0];
endfunction

function automatic logic [7:0] model_logic(input logic [7:0] res);
	m_sreg[3] = 1'b0;
	m_sreg[2] = res[7];
	m_sreg[4] = res[7];
	m_sreg[1] = (res == 8'h00);
	return res;
endfunction

// returns the number of instructions up to the final self-loop
function automatic int run_reference();
	logic [15:0] pc_m;
	logic [15:0] op;
	logic [15:0] addr;
	logic [4:0] d;
	logic [4:0] r;
	logic [4:0] dh;
	logic [7:0] k;
	int steps;
	pc_m = 16'h0000;
	m_sreg = 8'h00;
	steps = 0;
	exp_list.delete();
	for (int i = 0; i < 32; i++)
		m_regs[i] = 8'h00;
	while (steps < MAX_STEPS) begin
		op = rom[pc_m[7:0]];
		steps++;
		if (op == 16'hCFFF)
			break;
		d = op[8:4];
		r = {op[9], op[3:0]};
		dh = {1'b1, op[7:4]};
		k = {op[11:8], op[3:0]};
		pc_m = pc_m + 16'd1;
		casez (op)
			16'b0000_01??_????_????: void'(model_arith(m_regs[d], m_regs[r], 1'b1, 1'b1));
			16'b0000_10??_????_????: m_regs[d] = model_arith(m_regs[d], m_regs[r], 1'b1, 1'b1);
			16'b0000_11??_????_????: m_regs[d] = model_arith(m_regs[d], m_regs[r], 1'b0, 1'b0);
			16'b0001_01??_????_????: void'(model_arith(m_regs[d], m_regs[r], 1'b1, 1'b0));
			16'b0001_10??_????_????: m_regs[d] = model_arith(m_regs[d], m_regs[r], 1'b1, 1'b0);
			16'b0001_11??_????_????: m_regs[d] = model_arith(m_regs[d], m_regs[r], 1'b0, 1'b1);
			16'b0010_00??_????_????: m_regs[d] = model_logic(m_regs[d] & m_regs[r]);
			16'b0010_01??_????_????: m_regs[d] = model_logic(m_regs[d] ^ m_regs[r]);
			16'b0010_10??_????_????: m_regs[d] = model_logic(m_regs[d] | m_regs[r]);
			16'b0010_11??_????_????: m_regs[d] = m_regs[r];
			16'b0011_????_????_????: void'(model_arith(m_regs[dh], k, 1'b1, 1'b0));
			16'b0100_????_????_????: m_regs[dh] = model_arith(m_regs[dh], k, 1'b1, 1'b1);
			16'b0101_????_????_????: m_regs[dh] = model_arith(m_regs[dh], k, 1'b1, 1'b0);
			16'b0110_????_????_????: m_regs[dh] = model_logic(m_regs[dh] | k);
			16'b0111_????_????_????: m_regs[dh] = model_logic(m_regs[dh] & k);
			16'b1011_1???_????_????: begin
				addr = {10'b0, op[10:9], op[3:0]} + 16'h0020;
				exp_list.push_back({addr, m_regs[d]});
			end
			16'b1100_????_????_????: pc_m = pc_m + {{4{op[11]}}, op[11:0]};
			16'b1110_????_????_????: m_regs[dh] = k;
			// BRBS when bit 10 is clear, BRBC when set
			16'b1111_0???_????_????: begin
				if (m_sreg[op[2:0]] == !op[10])
					pc_m = pc_m + {{9{op[9]}}, op[9:3]};
			end
			default: begin
			end
		endcase
	end
	return steps;
endfunction

`endif

// File: tb/risc8_tb.sv
/*
 * risc8 core testbench
 * builds small programs in a ROM, runs them on the DUT and checks
 * every I/O write against the instruction-set model
 */
`timescale 1ns/1ps
`default_nettype none

module risc8_tb;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_STEPS = 2000;

	logic clk;
	logic reset;
	risc8_pkg::word_t cdata = '0;
	risc8_pkg::pc_t pc;
	logic io_wen;
	risc8_pkg::io_addr_t io_addr;
	risc8_pkg::byte_t io_data;

	logic [15:0] rom [256];
	// expected writes, address in the upper 16 bits
	logic [23:0] exp_list [$];
	int exp_idx = 0;
	int cmp_errors = 0;
	int pass_count = 0;
	int fail_count = 0;
	int seed = 32'hc53b;
	int limit_cycles = RESET_CYCLES + 8;
	int cycles = 0;
	int wp;
	logic in_reset = 1'b0;

	`include "risc8_ref.svh"

	risc8_core #(.RESET_PC(16'h0000)) i_dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.io_wen(io_wen),
		.io_addr(io_addr),
		.io_data(io_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// program memory, one clock of latency
	always @(posedge clk)
		cdata <= rom[pc[7:0]];

	function automatic logic [7:0] rnd8();
		logic [31:0] v;
		v = $random(seed);
		return v[7:0];
	endfunction

	function automatic logic [5:0] rnd6();
		logic [31:0] v;
		v = $random(seed);
		return v[5:0];
	endfunction

	function automatic logic [15:0] enc_ldi(input logic [4:0] d, input logic [7:0] k);
		return {4'hE, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic logic [15:0] enc_imm(input logic [3:0] code, input logic [4:0] d,
			input logic [7:0] k);
		return {code, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic logic [15:0] enc_rr(input logic [5:0] code, input logic [4:0] d,
			input logic [4:0] r);
		return {code, r[4], d, r[3:0]};
	endfunction

	function automatic logic [15:0] enc_out(input logic [5:0] a, input logic [4:0] r);
		return {5'b10111, a[5:4], r, a[3:0]};
	endfunction

	// set high means BRBS
	function automatic logic [15:0] enc_br(input logic set, input logic [2:0] s,
			input logic [6:0] off);
		return {5'b11110, ~set, off, s};
	endfunction

	task automatic emit(input logic [15:0] op);
		rom[wp[7:0]] = op;
		wp++;
	endtask

	// flag b shows up as A0+b when clear, B0+b when set
	task automatic emit_sreg_ladder(input int nbits, input logic [5:0] io);
		for (int b = 0; b < nbits; b++) begin
			emit(enc_ldi(5'd30, 8'hA0 | b[7:0]));
			emit(enc_br(1'b0, b[2:0], 7'd1));
			emit(enc_ldi(5'd30, 8'hB0 | b[7:0]));
			emit(enc_out(io, 5'd30));
		end
	endtask

	task automatic build_ldi_out();
		for (int i = 0; i < 16; i++) begin
			emit(enc_ldi(5'd16 + i[4:0], rnd8()));
			emit(enc_out(rnd6(), 5'd16 + i[4:0]));
		end
	endtask

	task automatic build_alu_chain();
		logic [5:0] codes [8];
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] z;
		// ADD ADC SUB SBC AND OR EOR MOV
		codes = '{6'h03, 6'h07, 6'h06, 6'h02, 6'h08, 6'h0A, 6'h09, 6'h0B};
		for (int i = 0; i < 8; i++)
			emit(enc_ldi(5'd16 + i[4:0], rnd8()));
		// eight registers only, so most ops depend on the one before
		for (int i = 0; i < 8; i++) begin
			x = rnd8();
			y = rnd8();
			z = rnd8();
			emit(enc_rr(codes[x[2:0]], {2'b10, y[2:0]}, {2'b10, z[2:0]}));
			emit(enc_out(rnd6(), {2'b10, y[2:0]}));
			emit_sreg_ladder(6, rnd6());
		end
	endtask

	task automatic build_immediate();
		logic [3:0] codes [5];
		logic [7:0] x;
		logic [7:0] y;
		logic [4:0] d;
		// SUBI SBCI ANDI ORI CPI
		codes = '{4'h5, 4'h4, 4'h7, 4'h6, 4'h3};
		for (int i = 0; i < 5; i++)
			emit(enc_ldi(5'd16 + i[4:0], rnd8()));
		for (int i = 0; i < 10; i++) begin
			x = rnd8() % 8'd5;
			y = rnd8() % 8'd5;
			d = 5'd16 + y[4:0];
			emit(enc_imm(codes[x], d, rnd8()));
			emit(enc_out(rnd6(), d));
			emit_sreg_ladder(4, rnd6());
		end
	endtask

	task automatic build_compare();
		logic [7:0] a [3];
		logic [7:0] b [3];
		for (int i = 0; i < 6; i++) begin
			for (int j = 0; j < 3; j++) begin
				a[j] = rnd8();
				b[j] = rnd8();
			end
			// equal values, then equal upper bytes over a low byte
			// that differs with no borrow, then random
			if (i % 3 == 0)
				b = a;
			else if (i % 3 == 1) begin
				a[0] = a[0] | 8'h80;
				b[0] = a[0] & 8'h7F;
				b[1] = a[1];
				b[2] = a[2];
			end
			// low byte goes last so CP reads r19 straight off the write port
			for (int j = 2; j >= 0; j--) begin
				emit(enc_ldi(5'd16 + j[4:0], a[j]));
				emit(enc_ldi(5'd19 + j[4:0], b[j]));
			end
			emit(enc_rr(6'h05, 5'd16, 5'd19));
			emit(enc_rr(6'h01, 5'd17, 5'd20));
			emit(enc_rr(6'h01, 5'd18, 5'd21));
			// marker 22 when the whole value compared equal
			emit(enc_br(1'b1, 3'd1, 7'd2));
			emit(enc_ldi(5'd22, 8'h11));
			emit({4'hC, 12'd1});
			emit(enc_ldi(5'd22, 8'h22));
			emit(enc_out(rnd6(), 5'd22));
			emit_sreg_ladder(4, rnd6());
		end
	endtask

	task automatic build_flow();
		logic [7:0] n;
		n = rnd8() % 8'd7 + 8'd2;
		emit(enc_ldi(5'd16, 8'h5A));
		// the first two OUTs are jumped over
		emit({4'hC, 12'd2});
		emit(enc_out(6'd1, 5'd16));
		emit(enc_out(6'd2, 5'd16));
		emit(enc_out(6'd3, 5'd16));
		emit(enc_ldi(5'd17, n));
		// count down with SUBI 1 until Z
		emit(enc_out(6'd4, 5'd17));
		emit(enc_imm(4'h5, 5'd17, 8'd1));
		emit(enc_br(1'b0, 3'd1, 7'h7D));
		emit(enc_out(6'd5, 5'd17));
	endtask

	always @(posedge clk) begin
		if (reset) begin
			if (in_reset && io_wen) begin
				$display("I/O write strobe was high while the core was in reset");
				cmp_errors++;
			end
			if (in_reset && pc !== 16'h0000) begin
				$display("[ERROR] pc: expected %h, got %h", 16'h0000, pc);
				cmp_errors++;
			end
			in_reset = 1'b1;
			exp_idx = 0;
		end else begin
			in_reset = 1'b0;
			if (io_wen) begin
				if (exp_idx >= exp_list.size()) begin
					$display("extra I/O write to %h after all %0d expected writes",
						io_addr, exp_list.size());
					cmp_errors++;
				end else begin
					if (io_addr !== exp_list[exp_idx][23:8]) begin
						$display("[ERROR] io_addr: expected %h, got %h",
							exp_list[exp_idx][23:8], io_addr);
						cmp_errors++;
					end
					if (io_data !== exp_list[exp_idx][7:0]) begin
						$display("[ERROR] io_data: expected %h, got %h",
							exp_list[exp_idx][7:0], io_data);
						cmp_errors++;
					end
					exp_idx++;
				end
			end
		end
	end

	task automatic run_test(input int id, input string name, input logic mid);
		int steps;
		int errs;
		int base;
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		base = cmp_errors;
		errs = 0;
		// no-op fill, the low byte follows the address
		for (int i = 0; i < 256; i++)
			rom[i] = {8'h00, i[7:0]};
		wp = 0;
		case (id)
			1: build_ldi_out();
			2: build_alu_chain();
			3: build_immediate();
			4: build_compare();
			5: build_flow();
			default: build_alu_chain();
		endcase
		emit(16'hCFFF);
		steps = run_reference();
		limit_cycles = limit_cycles + steps * 4 + RESET_CYCLES * 2 + 8;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		if (mid) begin
			// reset halfway through the write list
			while (exp_idx < exp_list.size() / 2)
				@(negedge clk);
			@(posedge clk);
			reset <= 1'b1;
			repeat (RESET_CYCLES) @(posedge clk);
			reset <= 1'b0;
		end
		@(posedge clk);
		while (cdata != 16'hCFFF)
			@(posedge clk);
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (exp_idx != exp_list.size()) begin
			$display("only %0d of %0d I/O writes came before the final loop",
				exp_idx, exp_list.size());
			errs++;
		end
		errs = errs + cmp_errors - base;
		if (errs == 0)
			pass_count++;
		else
			fail_count++;
		$display("test %0d %s: %s, %0d writes, %0d errors", id, name,
			(errs == 0) ? "ok" : "FAILED", exp_list.size(), errs);
	endtask

	initial begin
		reset = 1'b1;
		run_test(1, "ldi_out", 1'b0);
		run_test(2, "alu_chain", 1'b0);
		run_test(3, "immediate", 1'b0);
		run_test(4, "compare_branch", 1'b0);
		run_test(5, "rjmp_loop", 1'b0);
		run_test(6, "mid_reset", 1'b1);
		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// limit grows as each test adds its program length
	initial begin
		while (cycles <= limit_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the program never reached its final loop", cycles);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/risc8_core.sv
/*
 * risc8 core, two-stage AVR subset
 * stage one decodes the fetched opcode and starts register reads,
 * stage two runs the ALU, writes back and updates SREG
 * OUT takes a second cycle to drive the I/O write port
 */
`timescale 1ns/1ps
`default_nettype none

module risc8_core #(
	parameter risc8_pkg::pc_t RESET_PC = 16'h0000
) (
	input wire clk,
	input wire reset,
	output risc8_pkg::pc_t pc,
	input wire risc8_pkg::word_t cdata,
	output logic io_wen,
	output risc8_pkg::io_addr_t io_addr,
	output risc8_pkg::byte_t io_data
);
	// bubble loaded into stage two, moves nothing and keeps SREG
	localparam risc8_pkg::exec_ctrl_t EXEC_NOP = '{op: risc8_pkg::ALU_MOVR, default: '0};

	// address of the opcode currently on cdata
	risc8_pkg::pc_t reg_pc;
	risc8_pkg::pc_t next_pc;
	risc8_pkg::pc_t jump_target;
	risc8_pkg::step_e step;
	risc8_pkg::step_e next_step;
	// low for the first cycle after reset, cdata not yet valid
	logic fetch_valid;
	risc8_pkg::word_t held_op;
	risc8_pkg::word_t opcode;
	risc8_pkg::sreg_t sreg;
	risc8_pkg::sreg_t next_sreg;
	risc8_pkg::reg_sel_t sel_ra;
	risc8_pkg::reg_sel_t sel_rb;
	risc8_pkg::byte_t ra;
	risc8_pkg::byte_t rb;
	risc8_pkg::byte_t alu_rr;
	risc8_pkg::byte_t alu_result;
	risc8_pkg::exec_ctrl_t exec;
	risc8_pkg::exec_ctrl_t exec_q;
	risc8_pkg::flow_ctrl_t flow;
	logic branch_taken;

	// second OUT cycle works on the held word
	assign opcode = (step == risc8_pkg::STEP_FIRST) ? cdata : held_op;

	risc8_decode i_decode (
		.opcode(opcode),
		.sel_ra(sel_ra),
		.sel_rb(sel_rb),
		.exec(exec),
		.flow(flow)
	);

	risc8_regs i_regs (
		.clk(clk),
		.reset(reset),
		.sel_ra(sel_ra),
		.sel_rb(sel_rb),
		.ra(ra),
		.rb(rb),
		.sel_rd(exec_q.sel_rd),
		.write(exec_q.store),
		.rd(alu_result)
	);

	// constant for immediates, otherwise Rr
	assign alu_rr = exec_q.use_const ? exec_q.const_value : rb;

	risc8_alu i_alu (
		.op(exec_q.op),
		.use_carry(exec_q.use_carry),
		.rd_in(ra),
		.rr_in(alu_rr),
		.sreg_in(sreg),
		.result(alu_result),
		.sreg_out(next_sreg)
	);

	// branches see the flags of the instruction still in stage two
	assign jump_target = reg_pc + flow.offset + 16'd1;
	assign branch_taken = flow.is_branch && (next_sreg[flow.bit_select] == flow.bit_set);

	always_comb begin
		next_pc = reg_pc + 16'd1;
		next_step = risc8_pkg::STEP_FIRST;
		if (!fetch_valid) begin
			// refetch the reset address
			next_pc = reg_pc;
		end else if (step == risc8_pkg::STEP_FIRST) begin
			if (flow.is_rjmp || branch_taken) begin
				next_pc = jump_target;
			end else if (flow.is_out) begin
				// hold while the source register is read
				next_pc = reg_pc;
				next_step = risc8_pkg::STEP_SECOND;
			end
		end
	end

	// the fetch address goes out combinationally, no delay slot
	assign pc = next_pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_pc <= RESET_PC;
			fetch_valid <= 1'b0;
			step <= risc8_pkg::STEP_FIRST;
			sreg <= '0;
			exec_q <= EXEC_NOP;
		end else begin
			reg_pc <= next_pc;
			fetch_valid <= 1'b1;
			step <= next_step;
			sreg <= next_sreg;
			exec_q <= fetch_valid ? exec : EXEC_NOP;
		end
	end

	always_ff @(posedge clk) begin
		if (step == risc8_pkg::STEP_FIRST)
			held_op <= cdata;
	end

	// I/O write, exactly one cycle per OUT
	assign io_wen = (step == risc8_pkg::STEP_SECOND);
	assign io_addr = {10'b0, flow.io_num} + risc8_pkg::IO_BASE;
	assign io_data = ra;

endmodule

`default_nettype wire

// File: src/risc8_alu.sv
/*
 * risc8 ALU
 * 8-bit add/subtract with carry, logic ops and move,
 * status flags follow the AVR rules
 */
`timescale 1ns/1ps
`default_nettype none

module risc8_alu (
	input wire risc8_pkg::alu_op_e op,
	input wire use_carry,
	input wire risc8_pkg::byte_t rd_in,
	input wire risc8_pkg::byte_t rr_in,
	input wire risc8_pkg::sreg_t sreg_in,
	output risc8_pkg::byte_t result,
	output risc8_pkg::sreg_t sreg_out
);
	logic carry_in;
	logic is_arith;
	logic z_chain;
	risc8_pkg::byte_t arith;
	logic arith_c;
	logic arith_h;
	logic arith_v;

	assign carry_in = use_carry & sreg_in[risc8_pkg::FLAG_C];
	assign is_arith = (op == risc8_pkg::ALU_ADD) || (op == risc8_pkg::ALU_SUB);
	// SBC, SBCI and CPC keep Z only if every byte so far was zero
	assign z_chain = (op == risc8_pkg::ALU_SUB) & use_carry;

	// adder and subtractor with AVR carry, half carry and overflow
	always_comb begin
		if (op == risc8_pkg::ALU_SUB) begin
			arith = rd_in - rr_in - {7'b0, carry_in};
			arith_h = (~rd_in[3] & rr_in[3]) | (rr_in[3] & arith[3]) | (arith[3] & ~rd_in[3]);
			arith_c = (~rd_in[7] & rr_in[7]) | (rr_in[7] & arith[7]) | (arith[7] & ~rd_in[7]);
			arith_v = (rd_in[7] & ~rr_in[7] & ~arith[7]) | (~rd_in[7] & rr_in[7] & arith[7]);
		end else begin
			arith = rd_in + rr_in + {7'b0, carry_in};
			arith_h = (rd_in[3] & rr_in[3]) | (rr_in[3] & ~arith[3]) | (~arith[3] & rd_in[3]);
			arith_c = (rd_in[7] & rr_in[7]) | (rr_in[7] & ~arith[7]) | (~arith[7] & rd_in[7]);
			arith_v = (rd_in[7] & rr_in[7] & ~arith[7]) | (~rd_in[7] & ~rr_in[7] & arith[7]);
		end
	end

	always_comb begin
		sreg_out = sreg_in;

		case (op)
			risc8_pkg::ALU_ADD,
			risc8_pkg::ALU_SUB: result = arith;
			risc8_pkg::ALU_AND: result = rd_in & rr_in;
			risc8_pkg::ALU_OR: result = rd_in | rr_in;
			risc8_pkg::ALU_EOR: result = rd_in ^ rr_in;
			// MOV and LDI pass the second operand
			default: result = rr_in;
		endcase

		if (is_arith) begin
			sreg_out[risc8_pkg::FLAG_C] = arith_c;
			sreg_out[risc8_pkg::FLAG_H] = arith_h;
			sreg_out[risc8_pkg::FLAG_V] = arith_v;
		end else if (op != risc8_pkg::ALU_MOVR) begin
			// logic ops clear overflow, C and H untouched
			sreg_out[risc8_pkg::FLAG_V] = 1'b0;
		end

		// move leaves every flag alone
		if (op != risc8_pkg::ALU_MOVR) begin
			sreg_out[risc8_pkg::FLAG_N] = result[7];
			sreg_out[risc8_pkg::FLAG_S] = result[7] ^ sreg_out[risc8_pkg::FLAG_V];
			sreg_out[risc8_pkg::FLAG_Z] = (result == 8'h00)
				&& (!z_chain || sreg_in[risc8_pkg::FLAG_Z]);
		end
	end

endmodule

`default_nettype wire

// File: src/risc8_regs.sv
/*
 * risc8 register file
 * 32 bytes, two registered read ports and one write port,
 * a write is forwarded to a read of the same register
 */
`timescale 1ns/1ps
`default_nettype none

module risc8_regs (
	input wire clk,
	input wire reset,
	input wire risc8_pkg::reg_sel_t sel_ra,
	input wire risc8_pkg::reg_sel_t sel_rb,
	output risc8_pkg::byte_t ra,
	output risc8_pkg::byte_t rb,
	input wire risc8_pkg::reg_sel_t sel_rd,
	input wire write,
	input wire risc8_pkg::byte_t rd
);
	risc8_pkg::byte_t mem [32];
	logic wen;

	// no writes while the pipeline is being reset
	assign wen = write & ~reset;

	always_ff @(posedge clk) begin
		if (wen)
			mem[sel_rd] <= rd;

		// bypass so a dependent instruction needs no stall
		if (wen && sel_rd == sel_ra)
			ra <= rd;
		else
			ra <= mem[sel_ra];

		if (wen && sel_rd == sel_rb)
			rb <= rd;
		else
			rb <= mem[sel_rb];
	end

endmodule

`default_nettype wire

// File: src/risc8_decode.sv
/*
 * risc8 instruction decoder
 * purely combinational, turns one opcode word into register
 * selects, stage-two ALU control and stage-one flow control
 */
`timescale 1ns/1ps
`default_nettype none

module risc8_decode (
	input wire risc8_pkg::word_t opcode,
	output risc8_pkg::reg_sel_t sel_ra,
	output risc8_pkg::reg_sel_t sel_rb,
	output risc8_pkg::exec_ctrl_t exec,
	output risc8_pkg::flow_ctrl_t flow
);
	// immediate forms only reach r16-r31
	risc8_pkg::reg_sel_t rd_imm;
	risc8_pkg::byte_t k_imm;
	logic imm;

	assign rd_imm = {1'b1, opcode[7:4]};
	assign k_imm = {opcode[11:8], opcode[3:0]};

	always_comb begin
		// two-register form by default
		sel_ra = opcode[8:4];
		sel_rb = {opcode[9], opcode[3:0]};
		imm = 1'b0;

		// anything not matched below retires as a no-op
		exec.op = risc8_pkg::ALU_MOVR;
		exec.use_carry = 1'b0;
		exec.use_const = 1'b0;
		exec.const_value = '0;
		exec.store = 1'b0;
		exec.sel_rd = opcode[8:4];

		flow.is_rjmp = 1'b0;
		flow.is_branch = 1'b0;
		flow.bit_select = opcode[2:0];
		// BRBS has bit 10 clear and branches on a set flag
		flow.bit_set = ~opcode[10];
		flow.offset = '0;
		flow.is_out = 1'b0;
		flow.io_num = {opcode[10:9], opcode[3:0]};

		// Rd field is a wildcard everywhere
		casez (opcode)
			// CPC, flags only
			16'b0000_01??_????_????: begin
				exec.op = risc8_pkg::ALU_SUB;
				exec.use_carry = 1'b1;
			end
			// SBC
			16'b0000_10??_????_????: begin
				exec.op = risc8_pkg::ALU_SUB;
				exec.use_carry = 1'b1;
				exec.store = 1'b1;
			end
			// ADD
			16'b0000_11??_????_????: begin
				exec.op = risc8_pkg::ALU_ADD;
				exec.store = 1'b1;
			end
			// CP
			16'b0001_01??_????_????: exec.op = risc8_pkg::ALU_SUB;
			// SUB
			16'b0001_10??_????_????: begin
				exec.op = risc8_pkg::ALU_SUB;
				exec.store = 1'b1;
			end
			// ADC
			16'b0001_11??_????_????: begin
				exec.op = risc8_pkg::ALU_ADD;
				exec.use_carry = 1'b1;
				exec.store = 1'b1;
			end
			16'b0010_00??_????_????: begin
				exec.op = risc8_pkg::ALU_AND;
				exec.store = 1'b1;
			end
			16'b0010_01??_????_????: begin
				exec.op = risc8_pkg::ALU_EOR;
				exec.store = 1'b1;
			end
			16'b0010_10??_????_????: begin
				exec.op = risc8_pkg::ALU_OR;
				exec.store = 1'b1;
			end
			// MOV, the result is simply Rr
			16'b0010_11??_????_????: exec.store = 1'b1;
			// CPI never writes back
			16'b0011_????_????_????: begin
				exec.op = risc8_pkg::ALU_SUB;
				imm = 1'b1;
			end
			// SBCI
			16'b0100_????_????_????: begin
				exec.op = risc8_pkg::ALU_SUB;
				exec.use_carry = 1'b1;
				exec.store = 1'b1;
				imm = 1'b1;
			end
			// SUBI
			16'b0101_????_????_????: begin
				exec.op = risc8_pkg::ALU_SUB;
				exec.store = 1'b1;
				imm = 1'b1;
			end
			// ORI
			16'b0110_????_????_????: begin
				exec.op = risc8_pkg::ALU_OR;
				exec.store = 1'b1;
				imm = 1'b1;
			end
			// ANDI
			16'b0111_????_????_????: begin
				exec.op = risc8_pkg::ALU_AND;
				exec.store = 1'b1;
				imm = 1'b1;
			end
			// OUT, source register sits in the Rd field
			16'b1011_1???_????_????: flow.is_out = 1'b1;
			// RJMP, 12-bit signed word offset
			16'b1100_????_????_????: begin
				flow.is_rjmp = 1'b1;
				flow.offset = {{4{opcode[11]}}, opcode[11:0]};
			end
			// LDI goes through the move path
			16'b1110_????_????_????: begin
				exec.store = 1'b1;
				imm = 1'b1;
			end
			// BRBS / BRBC, 7-bit signed word offset
			16'b1111_0???_????_????: begin
				flow.is_branch = 1'b1;
				flow.offset = {{9{opcode[9]}}, opcode[9:3]};
			end
			default: begin
			end
		endcase

		// immediate forms share Rd 16-31 and the constant K
		if (imm) begin
			sel_ra = rd_imm;
			exec.sel_rd = rd_imm;
			exec.use_const = 1'b1;
			exec.const_value = k_imm;
		end
	end

endmodule

`default_nettype wire

// File: src/risc8_pkg.sv
/*
 * risc8 shared types
 * widths, status flag positions, ALU op and step encodings,
 * and the control bundles passed from decode into the core
 */
`default_nettype none

package risc8_pkg;

	// plain vector widths
	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [15:0] pc_t;
	typedef logic [4:0] reg_sel_t;
	typedef logic [15:0] io_addr_t;
	typedef logic [7:0] sreg_t;

	// status register bit positions, AVR order
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 3;
	localparam int FLAG_S = 4;
	localparam int FLAG_H = 5;
	localparam int FLAG_T = 6;
	localparam int FLAG_I = 7;

	// the 6-bit I/O number maps into data space from here
	localparam io_addr_t IO_BASE = 16'h0020;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_MOVR
	} alu_op_e;

	// OUT is the only instruction with a second cycle
	typedef enum logic {
		STEP_FIRST,
		STEP_SECOND
	} step_e;

	// stage two, latched by the core one clock after decode
	typedef struct packed {
		alu_op_e op;
		logic use_carry;
		logic use_const;
		byte_t const_value;
		logic store;
		reg_sel_t sel_rd;
	} exec_ctrl_t;

	// stage one, consumed by the PC logic in the same cycle
	typedef struct packed {
		logic is_rjmp;
		logic is_branch;
		logic [2:0] bit_select;
		logic bit_set;
		pc_t offset;
		logic is_out;
		logic [5:0] io_num;
	} flow_ctrl_t;

endpackage

`default_nettype wire
